// ==== common/min_trig_pkg.sv ====
`default_nettype none

package min_trig_pkg;

    // Stream widths
    localparam int S_AXIS_TDATA_WIDTH = 128;
    localparam int M_AXIS_TDATA_WIDTH = 64;

    // ADC lane layout, 12-bit samples in 16-bit lanes
    localparam int LANES = 8;
    localparam int LANE_WIDTH = 16;
    localparam int ADC_RESOLUTION_WIDTH = 12;
    localparam int ADC_FULL_SCALE = 1 << ADC_RESOLUTION_WIDTH;

    // Trigger level offset below baseline
    localparam int THRESHOLD_PCT = 10;
    localparam int THRESHOLD_COUNTS = THRESHOLD_PCT * ADC_FULL_SCALE / 100;

    // Baseline averaging over 16 beats of 8 lanes
    localparam int BASELINE_CALC_LEN = 16;
    localparam int BL_CNT_WIDTH = $clog2(BASELINE_CALC_LEN);
    localparam int BL_SHIFT = $clog2(BASELINE_CALC_LEN * LANES);
    localparam int BL_SUM_WIDTH = ADC_RESOLUTION_WIDTH + BL_SHIFT;

    // Record layout
    localparam int PRE_ACQUI_LEN = 4;
    localparam int POST_ACQUI_LEN = 3;
    localparam int ACQUI_LEN = PRE_ACQUI_LEN + 1 + POST_ACQUI_LEN;
    localparam int DLY_LEN = PRE_ACQUI_LEN + 1;
    localparam int WIN_CNT_WIDTH = $clog2(ACQUI_LEN + 1);

    localparam int TIME_STAMP_WIDTH = 16;

    // Record FIFO, depth must be a power of two
    localparam int FIFO_DEPTH = 32;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
    localparam int RDY_MIN_FREE = 2;

    typedef logic [ADC_RESOLUTION_WIDTH-1:0] adc_sample_t;
    typedef logic [TIME_STAMP_WIDTH-1:0]     time_stamp_t;
    typedef logic [S_AXIS_TDATA_WIDTH-1:0]   beat_t;
    typedef logic [M_AXIS_TDATA_WIDTH-1:0]   word_t;

    typedef enum logic {
        EXEC_INIT,
        EXEC_TRG
    } exec_state_t;

    // Header entries carry the timestamp in the low payload bits
    typedef struct packed {
        logic  first;
        logic  last;
        beat_t payload;
    } acq_entry_t;

endpackage

`default_nettype wire

// ==== logic/baseline_calc.sv ====
`timescale 1ns/10ps
`default_nettype none

module baseline_calc import min_trig_pkg::*;
(
    input  wire         AXIS_ACLK,
    input  wire         AXIS_ARESETN,
    input  exec_state_t exec_state,
    input  logic        accept,
    input  beat_t       s_axis_tdata,
    output adc_sample_t base_line,
    output logic        bl_calc_comp
);

    logic [BL_CNT_WIDTH-1:0] bl_cnt;
    logic [BL_SUM_WIDTH-1:0] acc;
    logic [BL_SUM_WIDTH-1:0] beat_sum;
    logic [BL_SUM_WIDTH-1:0] total;

    // Sum of the eight lane samples of the current beat
    always_comb
    begin
        beat_sum = '0;
        for (int i = 0; i < LANES; i++)
        begin
            beat_sum = beat_sum
                + BL_SUM_WIDTH'(s_axis_tdata[i*LANE_WIDTH +: ADC_RESOLUTION_WIDTH]);
        end
    end

    assign total = acc + beat_sum;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            bl_cnt       <= '0;
            acc          <= '0;
            bl_calc_comp <= 1'b0;
        end
        else if (accept && exec_state == EXEC_INIT)
        begin
            acc    <= total;
            bl_cnt <= bl_cnt + 1'b1;
            if (bl_cnt == BL_CNT_WIDTH'(BASELINE_CALC_LEN - 1))
            begin
                bl_calc_comp <= 1'b1;
            end
        end
    end

    // Floor of the mean, taken on the last averaged beat
    always_ff @(posedge AXIS_ACLK)
    begin
        if (accept && exec_state == EXEC_INIT
            && bl_cnt == BL_CNT_WIDTH'(BASELINE_CALC_LEN - 1))
        begin
            base_line <= total[BL_SHIFT +: ADC_RESOLUTION_WIDTH];
        end
    end

    a_base_line_frozen: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (bl_calc_comp && $past(bl_calc_comp)) |-> $stable(base_line)
    );

endmodule

`default_nettype wire

// ==== trigger/min_trigger_detect.sv ====
`timescale 1ns/10ps
`default_nettype none

module min_trigger_detect import min_trig_pkg::*;
(
    input  wire         AXIS_ACLK,
    input  wire         AXIS_ARESETN,
    input  exec_state_t exec_state,
    input  logic        accept,
    input  beat_t       s_axis_tdata,
    input  adc_sample_t base_line,
    output beat_t       win_beat,
    output logic        win_valid,
    output logic        win_first,
    output logic        win_last,
    output time_stamp_t time_stamp
);

    logic [ADC_RESOLUTION_WIDTH:0] thr_ext;
    logic [ADC_RESOLUTION_WIDTH:0] trig_ref;
    logic [LANES-1:0]              lane_hit;
    logic                          trig;
    logic                          win_open;
    logic [WIN_CNT_WIDTH-1:0]      win_cnt;
    time_stamp_t                   beat_cnt;
    beat_t                         dly [DLY_LEN];

    assign thr_ext  = (ADC_RESOLUTION_WIDTH + 1)'(THRESHOLD_COUNTS);
    assign trig_ref = {1'b0, base_line};

    // sample < base_line - threshold, rearranged so it cannot underflow
    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        assign lane_hit[i] =
            ({1'b0, s_axis_tdata[i*LANE_WIDTH +: ADC_RESOLUTION_WIDTH]} + thr_ext) < trig_ref;
    end

    // A window counts the trigger beat and the next 7 accepted beats,
    // so the beat after the last one may start a new record
    assign win_open = (win_cnt != '0) && (win_cnt != WIN_CNT_WIDTH'(ACQUI_LEN));
    assign trig     = (exec_state == EXEC_TRG) && (|lane_hit) && !win_open;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (accept)
        begin
            dly[0] <= s_axis_tdata;
            for (int k = 1; k < DLY_LEN; k++)
            begin
                dly[k] <= dly[k-1];
            end
        end
        if (accept && trig)
        begin
            time_stamp <= beat_cnt;
        end
    end

    // Oldest stage holds the beat presented to the writer
    assign win_beat = dly[DLY_LEN-1];

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            win_cnt   <= '0;
            beat_cnt  <= '0;
            win_valid <= 1'b0;
            win_first <= 1'b0;
            win_last  <= 1'b0;
        end
        else
        begin
            win_valid <= 1'b0;
            win_first <= 1'b0;
            win_last  <= 1'b0;
            if (exec_state == EXEC_INIT)
            begin
                beat_cnt <= '0;
                win_cnt  <= '0;
            end
            else if (accept)
            begin
                beat_cnt <= beat_cnt + 1'b1;
                if (trig)
                begin
                    win_cnt   <= WIN_CNT_WIDTH'(1);
                    win_valid <= 1'b1;
                    win_first <= 1'b1;
                end
                else if (win_open)
                begin
                    win_cnt   <= win_cnt + 1'b1;
                    win_valid <= 1'b1;
                    win_last  <= (win_cnt == WIN_CNT_WIDTH'(ACQUI_LEN - 1));
                end
                else
                begin
                    win_cnt <= '0;
                end
            end
        end
    end

    a_win_flags: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (win_first || win_last) |-> win_valid
    );

endmodule

`default_nettype wire

// ==== acquisition/acq_writer.sv ====
`timescale 1ns/10ps
`default_nettype none

module acq_writer import min_trig_pkg::*;
(
    input  wire                       AXIS_ACLK,
    input  wire                       AXIS_ARESETN,
    input  beat_t                     win_beat,
    input  logic                      win_valid,
    input  logic                      win_first,
    input  logic                      win_last,
    input  time_stamp_t               time_stamp,
    input  logic [FIFO_CNT_WIDTH-1:0] fifo_free,
    output logic                      s_axis_tready,
    output logic                      wr_en,
    output acq_entry_t                wr_entry
);

    logic                      hdr_stall;
    logic                      hdr_pend;
    logic                      run_q;
    logic [FIFO_CNT_WIDTH-1:0] min_free;

    // Header goes in while the first beat waits in the delay line
    assign hdr_stall = win_valid && win_first;

    always_comb
    begin
        wr_en            = 1'b0;
        wr_entry.first   = 1'b0;
        wr_entry.last    = 1'b0;
        wr_entry.payload = win_beat;
        if (hdr_stall)
        begin
            wr_en            = 1'b1;
            wr_entry.first   = 1'b1;
            wr_entry.payload = beat_t'(time_stamp);
        end
        else if (hdr_pend)
        begin
            // First record beat, never the last one
            wr_en = 1'b1;
        end
        else if (win_valid)
        begin
            wr_en         = 1'b1;
            wr_entry.last = win_last;
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            hdr_pend <= 1'b0;
            run_q    <= 1'b0;
        end
        else
        begin
            hdr_pend <= hdr_stall;
            run_q    <= 1'b1;
        end
    end

    // Free space must cover this cycle's write plus a header and its beat
    assign min_free = FIFO_CNT_WIDTH'(RDY_MIN_FREE) + FIFO_CNT_WIDTH'(wr_en);

    assign s_axis_tready = run_q && !hdr_stall && (fifo_free >= min_free);

    // Detector only strobes after an accept, and the stall blocks that
    a_pend_quiet: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        hdr_pend |-> !win_valid
    );

endmodule

`default_nettype wire

// ==== acquisition/acq_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module acq_fifo import min_trig_pkg::*;
(
    input  wire                       AXIS_ACLK,
    input  wire                       AXIS_ARESETN,
    input  logic                      wr_en,
    input  acq_entry_t                wr_entry,
    input  logic                      rd_en,
    output acq_entry_t                rd_entry,
    output logic                      empty,
    output logic [FIFO_CNT_WIDTH-1:0] fifo_free,
    output logic                      fifo_full
);

    acq_entry_t                mem [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_CNT_WIDTH-1:0] count;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    // Pointers wrap on their own
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + FIFO_CNT_WIDTH'(wr_en) - FIFO_CNT_WIDTH'(rd_en);
        end
    end

    // Head entry visible without a read cycle
    assign rd_entry  = mem[rd_ptr];
    assign empty     = (count == '0);
    assign fifo_full = (count == FIFO_CNT_WIDTH'(FIFO_DEPTH));
    assign fifo_free = FIFO_CNT_WIDTH'(FIFO_DEPTH) - count;

    a_no_overflow: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        wr_en |-> !fifo_full
    );

    a_no_underflow: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        rd_en |-> !empty
    );

endmodule

`default_nettype wire

// ==== acquisition/m_axis_packer.sv ====
`timescale 1ns/10ps
`default_nettype none

module m_axis_packer import min_trig_pkg::*;
(
    input  wire        AXIS_ACLK,
    input  wire        AXIS_ARESETN,
    input  acq_entry_t rd_entry,
    input  logic       empty,
    output logic       rd_en,
    output word_t      m_axis_tdata,
    output logic       m_axis_tvalid,
    output logic       m_axis_tlast,
    output logic       m_axis_tuser,
    input  logic       m_axis_tready
);

    logic half_q;
    logic load;

    // Output register free or draining this cycle
    assign load = !m_axis_tvalid || m_axis_tready;

    // Pop after a header word or the high half of a data entry
    assign rd_en = load && !empty && (rd_entry.first || half_q);

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
            m_axis_tuser  <= 1'b0;
            half_q        <= 1'b0;
        end
        else if (load)
        begin
            m_axis_tvalid <= !empty;
            if (!empty)
            begin
                m_axis_tuser <= rd_entry.first;
                m_axis_tlast <= half_q && rd_entry.last;
                half_q       <= !rd_entry.first && !half_q;
            end
        end
    end

    // Header payload is already the zero-extended timestamp
    always_ff @(posedge AXIS_ACLK)
    begin
        if (load && !empty)
        begin
            if (half_q)
            begin
                m_axis_tdata <= rd_entry.payload[S_AXIS_TDATA_WIDTH-1 -: M_AXIS_TDATA_WIDTH];
            end
            else
            begin
                m_axis_tdata <= rd_entry.payload[M_AXIS_TDATA_WIDTH-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/minimum_trigger.sv ====
`timescale 1ns/10ps
`default_nettype none

module minimum_trigger import min_trig_pkg::*;
(
    input  wire   AXIS_ACLK,
    input  wire   AXIS_ARESETN,

    // ADC sample stream
    input  beat_t s_axis_tdata,
    input  logic  s_axis_tvalid,
    output logic  s_axis_tready,

    // Record stream
    output word_t m_axis_tdata,
    output logic  m_axis_tvalid,
    output logic  m_axis_tlast,
    output logic  m_axis_tuser,
    input  logic  m_axis_tready,

    output logic  fifo_full
);

    logic                      accept;
    exec_state_t               exec_state;
    adc_sample_t               base_line;
    logic                      bl_calc_comp;
    beat_t                     win_beat;
    logic                      win_valid;
    logic                      win_first;
    logic                      win_last;
    time_stamp_t               time_stamp;
    logic [FIFO_CNT_WIDTH-1:0] fifo_free;
    logic                      wr_en;
    acq_entry_t                wr_entry;
    logic                      rd_en;
    acq_entry_t                rd_entry;
    logic                      empty;

    assign accept = s_axis_tvalid && s_axis_tready;

    // Armed as soon as the baseline is known
    assign exec_state = bl_calc_comp ? EXEC_TRG : EXEC_INIT;

    baseline_calc u_baseline_calc (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .exec_state   (exec_state),
        .accept       (accept),
        .s_axis_tdata (s_axis_tdata),
        .base_line    (base_line),
        .bl_calc_comp (bl_calc_comp)
    );

    min_trigger_detect u_min_trigger_detect (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .exec_state   (exec_state),
        .accept       (accept),
        .s_axis_tdata (s_axis_tdata),
        .base_line    (base_line),
        .win_beat     (win_beat),
        .win_valid    (win_valid),
        .win_first    (win_first),
        .win_last     (win_last),
        .time_stamp   (time_stamp)
    );

    acq_writer u_acq_writer (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .win_beat      (win_beat),
        .win_valid     (win_valid),
        .win_first     (win_first),
        .win_last      (win_last),
        .time_stamp    (time_stamp),
        .fifo_free     (fifo_free),
        .s_axis_tready (s_axis_tready),
        .wr_en         (wr_en),
        .wr_entry      (wr_entry)
    );

    acq_fifo u_acq_fifo (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .wr_en        (wr_en),
        .wr_entry     (wr_entry),
        .rd_en        (rd_en),
        .rd_entry     (rd_entry),
        .empty        (empty),
        .fifo_free    (fifo_free),
        .fifo_full    (fifo_full)
    );

    m_axis_packer u_m_axis_packer (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .rd_entry      (rd_entry),
        .empty         (empty),
        .rd_en         (rd_en),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tready (m_axis_tready)
    );

endmodule

`default_nettype wire

// ==== dv/tb_minimum_trigger.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_minimum_trigger import min_trig_pkg::*;
();

    localparam int unsigned SEED = 32'hae12_4f35;
    localparam int NUM_SEGS = 20;
    localparam int STALL_FIRST = 7;
    localparam int STALL_ROWS = 12;
    localparam int EXP_RECORDS = 3 + STALL_ROWS;
    localparam int CYCLES_PER_BEAT = 4;

    // Stimulus segment where a negative dip_idx means no dip
    typedef struct packed {
        int beats;
        int level;
        int lane;
        int offset;
        int dip_idx;
        int stall_pct;
    } seg_t;

    typedef struct packed {
        logic  user;
        logic  last;
        word_t data;
    } exp_word_t;

    logic  AXIS_ACLK = 1'b0;
    logic  AXIS_ARESETN;
    beat_t s_axis_tdata;
    logic  s_axis_tvalid;
    logic  s_axis_tready;
    word_t m_axis_tdata;
    logic  m_axis_tvalid;
    logic  m_axis_tlast;
    logic  m_axis_tuser;
    logic  m_axis_tready;
    logic  fifo_full;

    seg_t      segs [NUM_SEGS];
    exp_word_t exp_q [$];
    beat_t     hist [$];
    exp_word_t got_exp;

    int   errors = 0;
    int   checks = 0;
    int   cycles = 0;
    int   max_cycles = 0;
    int   words_out = 0;
    int   hdrs_out = 0;
    int   records = 0;
    int   bp_cycles = 0;
    int   stall_pct = 0;
    int   total_beats = 0;
    logic saw_full = 1'b0;
    logic in_stall_rows = 1'b0;

    // Reference model state
    int bl_sum = 0;
    int n_acc = 0;
    int baseline = 0;
    int armed_cnt = 0;
    int win_left = 0;
    int post_left = 0;

    minimum_trigger DUT (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tready (m_axis_tready),
        .fifo_full     (fifo_full)
    );

    always #4 AXIS_ACLK = ~AXIS_ACLK;

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic print_summary();
        $display("Checks: %0d, errors: %0d, records: %0d", checks, errors, records);
    endtask

    task automatic load_segments();
        segs[0] = '{16, 2048, 0, 0, -1, 0};
        segs[1] = '{40, 2050, 0, 0, -1, 20};
        segs[2] = '{24, 2047, 3, 420, 10, 30};
        // Exactly at the trigger level
        segs[3] = '{24, 2048, 5, 409, 8, 0};
        // Dip near the row end, then a second one three beats later
        segs[4] = '{24, 2049, 1, 430, 22, 25};
        segs[5] = '{20, 2048, 6, 500, 1, 25};
        segs[6] = '{20, 2046, 2, 440, 10, 25};
        for (int r = 0; r < STALL_ROWS; r++)
        begin
            segs[STALL_FIRST + r] = '{8, 2048, r % LANES, 450 + 4 * r, 0, 60};
        end
        segs[NUM_SEGS-1] = '{24, 2048, 0, 0, -1, 0};
    endtask

    function automatic int lane_sample(input beat_t b, input int i);
        return int'(b[i*LANE_WIDTH +: ADC_RESOLUTION_WIDTH]);
    endfunction

    function automatic beat_t make_beat(input seg_t s, input int idx);
        beat_t b;
        int    v;
        b = '0;
        for (int i = 0; i < LANES; i++)
        begin
            v = s.level + int'($urandom % 5) - 2;
            if (idx == s.dip_idx && i == s.lane)
            begin
                v = baseline - s.offset;
            end
            b[i*LANE_WIDTH +: LANE_WIDTH] = 16'(v);
        end
        return b;
    endfunction

    task automatic push_beat_words(input beat_t b, input logic last);
        exp_word_t w;
        w.user = 1'b0;
        w.last = 1'b0;
        w.data = b[63:0];
        exp_q.push_back(w);
        w.last = last;
        w.data = b[127:64];
        exp_q.push_back(w);
    endtask

    task automatic push_header(input int ts);
        exp_word_t w;
        w.user = 1'b1;
        w.last = 1'b0;
        w.data = {48'h0, ts[15:0]};
        exp_q.push_back(w);
    endtask

    task automatic model_accept(input beat_t b);
        int   ts;
        logic hit;
        hist.push_back(b);
        if (n_acc < BASELINE_CALC_LEN)
        begin
            for (int i = 0; i < LANES; i++)
            begin
                bl_sum += lane_sample(b, i);
            end
            n_acc++;
            if (n_acc == BASELINE_CALC_LEN)
            begin
                baseline = bl_sum / (BASELINE_CALC_LEN * LANES);
            end
        end
        else
        begin
            ts = armed_cnt;
            armed_cnt++;
            hit = 1'b0;
            for (int i = 0; i < LANES; i++)
            begin
                if (lane_sample(b, i) < baseline - THRESHOLD_COUNTS)
                begin
                    hit = 1'b1;
                end
            end
            if (post_left > 0)
            begin
                push_beat_words(b, post_left == 1);
                post_left--;
            end
            // Beats inside an open window never trigger
            if (win_left > 0)
            begin
                win_left--;
            end
            else if (hit)
            begin
                records++;
                push_header(ts);
                for (int k = PRE_ACQUI_LEN; k >= 1; k--)
                begin
                    push_beat_words(hist[hist.size()-1-k], 1'b0);
                end
                push_beat_words(b, 1'b0);
                post_left = POST_ACQUI_LEN;
                win_left  = ACQUI_LEN - 1;
            end
        end
    endtask

    // Holds the beat until accepted and redraws output ready on each falling edge
    task automatic send_beat(input beat_t b);
        logic taken;
        s_axis_tdata  = b;
        s_axis_tvalid = 1'b1;
        taken = 1'b0;
        while (!taken)
        begin
            @(posedge AXIS_ACLK);
            taken = s_axis_tready;
            @(negedge AXIS_ACLK);
            m_axis_tready = int'($urandom % 100) >= stall_pct;
        end
        model_accept(b);
    endtask

    always @(posedge AXIS_ACLK)
    begin
        cycles++;
        if (fifo_full)
        begin
            saw_full = 1'b1;
        end
        if (in_stall_rows && s_axis_tvalid && !s_axis_tready)
        begin
            bp_cycles++;
        end
        if (m_axis_tvalid && m_axis_tready)
        begin
            words_out++;
            if (m_axis_tuser)
            begin
                hdrs_out++;
            end
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("Unexpected output word %0h at %0d ns with no record word pending",
                    m_axis_tdata, $time);
            end
            else
            begin
                got_exp = exp_q.pop_front();
                check_eq(m_axis_tdata, got_exp.data, "m_axis_tdata");
                check_eq(m_axis_tuser, got_exp.user, "m_axis_tuser");
                check_eq(m_axis_tlast, got_exp.last, "m_axis_tlast");
            end
        end
        if (cycles > max_cycles)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
            print_summary();
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(SEED));
        AXIS_ARESETN  = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b0;
        load_segments();
        for (int s = 0; s < NUM_SEGS; s++)
        begin
            total_beats += segs[s].beats;
        end
        max_cycles = total_beats * CYCLES_PER_BEAT;

        repeat (3) @(posedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        check_eq(s_axis_tready, 1'b0, "s_axis_tready in reset");
        check_eq(m_axis_tvalid, 1'b0, "m_axis_tvalid in reset");
        check_eq(m_axis_tlast, 1'b0, "m_axis_tlast in reset");
        check_eq(m_axis_tuser, 1'b0, "m_axis_tuser in reset");
        check_eq(fifo_full, 1'b0, "fifo_full in reset");
        AXIS_ARESETN = 1'b1;

        for (int s = 0; s < NUM_SEGS; s++)
        begin
            stall_pct     = segs[s].stall_pct;
            in_stall_rows = (s >= STALL_FIRST) && (s < STALL_FIRST + STALL_ROWS);
            for (int i = 0; i < segs[s].beats; i++)
            begin
                send_beat(make_beat(segs[s], i));
            end
            // Baseline and flat armed beats alone
            if (s == 1)
            begin
                check_eq(words_out, 0, "output words before any dip");
                check_eq(saw_full, 1'b0, "fifo_full before any dip");
            end
        end

        s_axis_tvalid = 1'b0;
        in_stall_rows = 1'b0;
        stall_pct     = 0;
        m_axis_tready = 1'b1;
        while (exp_q.size() != 0)
        begin
            @(negedge AXIS_ACLK);
        end
        repeat (20) @(negedge AXIS_ACLK);

        check_eq(hdrs_out, EXP_RECORDS, "header words at the output");
        check_eq(saw_full, 1'b1, "fifo_full under output stalls");
        check_eq(bp_cycles > STALL_ROWS, 1'b1, "s_axis_tready drop under output stalls");
        check_eq(m_axis_tvalid, 1'b0, "m_axis_tvalid after drain");

        print_summary();
        if (errors == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
common/min_trig_pkg.sv
logic/baseline_calc.sv
trigger/min_trigger_detect.sv
acquisition/acq_writer.sv
acquisition/acq_fifo.sv
acquisition/m_axis_packer.sv
logic/minimum_trigger.sv
dv/tb_minimum_trigger.sv
